/* affine_golden.txt */
# Each record is a tag, then mantissas 0 to 3 and the shared exponent, all in hex
# W weight block, B bias block, N input block, O expected output block
# Tensor 0
W 40 e0 20 7f 0
W c0 10 60 01 1
B 10 f0 00 7f 0
B 40 81 05 fb 8
N 40 40 c0 20 0
N 20 f8 7f 80 0
N 81 7f 01 ff 7
N 00 7f 80 40 3
N 02 fe 04 00 d
N 7f 00 00 80 7
N 01 01 ff 00 7
N 10 f0 08 7f 8
O 18 f0 f8 4f 1
O f0 fe 5f fe 1
O 81 c0 00 00 6
O 00 0f a0 00 4
O 40 c0 00 fc e
O 81 ff 00 fd 7
O 50 d0 e0 7f 0
O 18 be 08 fe 9
# Tensor 1
W 7f 80 40 c0 7
W 20 e0 7f 01 8
B 40 90 7f 81 0
B 01 fe 03 00 8
N 7f 80 7f 7f 7
N 04 02 ff 10 0
N 10 08 f0 20 2
N 40 c0 40 80 c
N 00 01 fe 01 0
N 01 00 00 05 6
N 01 ff 00 02 8
N 81 7f 81 00 3
O 7f 7f 7f 80 7
O 02 fd 02 00 8
O 40 df e0 bf 7
O 02 ff 06 ff 8
O 20 88 ff a0 1
O 11 fe 03 02 8
O 40 90 7f 80 0
O e0 e0 82 00 b

/* mxint_affine.sv */
`timescale 1ns/1ps
`default_nettype none

module mxint_affine (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mxint_pkg::mx_block_t   norm_data,
  input  logic                   norm_valid,
  output logic                   norm_ready,
  input  mxint_pkg::mx_block_t   weight_data,
  input  logic                   weight_valid,
  output logic                   weight_ready,
  input  mxint_pkg::mx_block_t   bias_data,
  input  logic                   bias_valid,
  output logic                   bias_ready,
  output mxint_pkg::wide_block_t out_data,
  output logic                   out_valid,
  input  logic                   out_ready
);

  localparam int BLOCK_SIZE = mxint_pkg::BLOCK_SIZE;
  localparam int MAN_W      = mxint_pkg::MAN_W;
  localparam int WIDE_MAN_W = mxint_pkg::WIDE_MAN_W;
  localparam int WIDE_EXP_W = mxint_pkg::WIDE_EXP_W;
  localparam int PROD_W     = 2 * MAN_W;
  localparam int ALIGN_W    = WIDE_EXP_W + 2;  // Bias exponent minus product exponent, plus offset

  logic                         free;
  logic                         fire;
  logic signed [PROD_W-1:0]     prod [BLOCK_SIZE];
  logic signed [WIDE_EXP_W-1:0] prod_exp;
  logic signed [ALIGN_W-1:0]    bias_shift;
  logic        [ALIGN_W-1:0]    bias_rshift;
  logic signed [WIDE_MAN_W-1:0] bias_aligned [BLOCK_SIZE];
  mxint_pkg::wide_block_t       result;

  // Output register can take data when empty or emptied this cycle
  assign free = !out_valid || out_ready;

  // Each ready only looks at the other two valids, so no stream sees its own
  assign norm_ready   = free && weight_valid && bias_valid;
  assign weight_ready = free && norm_valid && bias_valid;
  assign bias_ready   = free && norm_valid && weight_valid;
  assign fire         = free && norm_valid && weight_valid && bias_valid;

  assign prod_exp = WIDE_EXP_W'($signed(weight_data.exp)) + WIDE_EXP_W'($signed(norm_data.exp));

  // Bias has MAN_W-1 fraction bits and the product twice as many so the shift gains MAN_W-1
  assign bias_shift = ALIGN_W'($signed(bias_data.exp)) - ALIGN_W'(prod_exp)
                    + ALIGN_W'(MAN_W - 1);
  assign bias_rshift = ALIGN_W'(-bias_shift);

  always_comb begin
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      prod[i] = PROD_W'($signed(weight_data.man[i])) * PROD_W'($signed(norm_data.man[i]));
      if (bias_shift < 0) begin
        // Arithmetic shift right floors toward minus infinity
        bias_aligned[i] = WIDE_MAN_W'($signed(bias_data.man[i])) >>> bias_rshift;
      end else begin
        bias_aligned[i] = WIDE_MAN_W'($signed(bias_data.man[i])) <<< bias_shift;
      end
    end
  end

  always_comb begin
    result.exp = prod_exp;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      result.man[i] = WIDE_MAN_W'(prod[i]) + bias_aligned[i];  // Wraps in WIDE_MAN_W bits
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      out_data <= result;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // A stalled result holds still until the cast takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* mxint_cast.sv */
`timescale 1ns/1ps
`default_nettype none

module mxint_cast (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mxint_pkg::wide_block_t in_data,
  input  logic                   in_valid,
  output logic                   in_ready,
  output mxint_pkg::mx_block_t   out_data,
  output logic                   out_valid,
  input  logic                   out_ready
);

  localparam int BLOCK_SIZE = mxint_pkg::BLOCK_SIZE;
  localparam int MAN_W      = mxint_pkg::MAN_W;
  localparam int EXP_W      = mxint_pkg::EXP_W;
  localparam int WIDE_MAN_W = mxint_pkg::WIDE_MAN_W;
  localparam int SH_W       = $clog2(WIDE_MAN_W - MAN_W + 1);
  localparam int CALC_W     = 8;  // Room for exponent arithmetic before the clamp
  localparam int EXT_W      = WIDE_MAN_W + 2;
  localparam int EXP_MAX    = 2 ** (EXP_W - 1) - 1;
  localparam int EXP_MIN    = -(2 ** (EXP_W - 1));
  localparam logic signed [EXT_W-1:0] SAT_HI = EXT_W'(2 ** (MAN_W - 1) - 1);
  localparam logic signed [EXT_W-1:0] SAT_LO = EXT_W'(-(2 ** (MAN_W - 1)));

  logic                     fire;
  logic [WIDE_MAN_W-2:0]    mag_or;
  logic [SH_W-1:0]          norm_shift;
  logic signed [CALC_W-1:0] exp_raw;
  logic signed [CALC_W-1:0] exp_clamped;
  logic signed [CALC_W-1:0] man_rshift;
  logic        [CALC_W-1:0] man_lshift;
  logic signed [EXT_W-1:0]  shifted [BLOCK_SIZE];
  mxint_pkg::mx_block_t     result;

  assign in_ready = !out_valid || out_ready;
  assign fire     = in_valid && in_ready;

  // Bits that differ from the sign over the whole block
  always_comb begin
    mag_or = '0;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      mag_or |= in_data.man[i][WIDE_MAN_W-2:0] ^ {(WIDE_MAN_W - 1){in_data.man[i][WIDE_MAN_W-1]}};
    end
  end

  // A leading bit at k needs k+2 signed bits
  always_comb begin
    norm_shift = '0;
    for (int k = MAN_W - 1; k < WIDE_MAN_W - 1; k++) begin
      if (mag_or[k]) norm_shift = SH_W'(k - MAN_W + 2);
    end
  end

  always_comb begin
    exp_raw = CALC_W'($signed(in_data.exp)) - CALC_W'(MAN_W - 1) + CALC_W'(norm_shift);
    if (exp_raw > EXP_MAX) begin
      exp_clamped = CALC_W'(EXP_MAX);
    end else if (exp_raw < EXP_MIN) begin
      exp_clamped = CALC_W'(EXP_MIN);
    end else begin
      exp_clamped = exp_raw;
    end
  end

  // Equals norm_shift unless the exponent was clamped
  assign man_rshift = exp_clamped - CALC_W'($signed(in_data.exp)) + CALC_W'(MAN_W - 1);
  assign man_lshift = CALC_W'(-man_rshift);

  always_comb begin
    result.exp = EXP_W'(exp_clamped);
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      if (man_rshift < 0) begin
        shifted[i] = EXT_W'($signed(in_data.man[i])) <<< man_lshift;
      end else begin
        shifted[i] = EXT_W'($signed(in_data.man[i])) >>> man_rshift;
      end
      if (shifted[i] > SAT_HI) begin
        result.man[i] = MAN_W'(SAT_HI);  // Only reached on a high clamp
      end else if (shifted[i] < SAT_LO) begin
        result.man[i] = MAN_W'(SAT_LO);
      end else begin
        result.man[i] = MAN_W'(shifted[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) out_data <= result;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // A stalled output block holds still until the consumer takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* mxint_circular.sv */
`timescale 1ns/1ps
`default_nettype none

module mxint_circular #(
  parameter int ROW_BLOCKS = 2,
  parameter int ROWS       = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mxint_pkg::mx_block_t in_data,
  input  logic                 in_valid,
  output logic                 in_ready,
  output mxint_pkg::mx_block_t out_data,
  output logic                 out_valid,
  input  logic                 out_ready
);

  localparam int IDX_W = (ROW_BLOCKS > 1) ? $clog2(ROW_BLOCKS) : 1;
  localparam int REP_W = (ROWS > 1) ? $clog2(ROWS) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(ROW_BLOCKS - 1);
  localparam logic [REP_W-1:0] LAST_REP = REP_W'(ROWS - 1);

  mxint_pkg::mx_block_t mem [ROW_BLOCKS];

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic [REP_W-1:0] rep_cnt;  // Row currently being replayed
  logic             loading;
  logic             load_fire;
  logic             rep_fire;

  // One row of blocks is loaded, then replayed once per tensor row
  assign in_ready  = loading;
  assign out_valid = !loading;
  assign out_data  = mem[rd_idx];

  assign load_fire = in_valid && in_ready;
  assign rep_fire  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (load_fire) begin
      mem[wr_idx] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      loading <= 1'b1;
      wr_idx  <= '0;
      rd_idx  <= '0;
      rep_cnt <= '0;
    end else if (loading) begin
      if (load_fire) begin
        if (wr_idx == LAST_IDX) begin
          wr_idx  <= '0;
          loading <= 1'b0;  // First block is offered on the next cycle
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
    end else if (rep_fire) begin
      if (rd_idx == LAST_IDX) begin
        rd_idx <= '0;
        if (rep_cnt == LAST_REP) begin
          // Every row has seen the parameters so the buffer waits for the next tensor
          rep_cnt <= '0;
          loading <= 1'b1;
        end else begin
          rep_cnt <= rep_cnt + 1'b1;
        end
      end else begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  // Replay starts at the first block of the first row right after the last load
  assert property (@(posedge clk) disable iff (!rst_n)
    load_fire && wr_idx == LAST_IDX |=> out_valid && rd_idx == '0 && rep_cnt == '0);

  // Replayed block holds still until the consumer takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* mxint_layernorm_affine.sv */
`timescale 1ns/1ps
`default_nettype none

module mxint_layernorm_affine #(
  parameter int ROW_BLOCKS = 2,
  parameter int ROWS       = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mxint_pkg::mx_block_t norm_in,
  input  logic                 norm_in_valid,
  output logic                 norm_in_ready,
  input  mxint_pkg::mx_block_t weight_in,
  input  logic                 weight_in_valid,
  output logic                 weight_in_ready,
  input  mxint_pkg::mx_block_t bias_in,
  input  logic                 bias_in_valid,
  output logic                 bias_in_ready,
  output mxint_pkg::mx_block_t data_out,
  output logic                 data_out_valid,
  input  logic                 data_out_ready
);

  mxint_pkg::mx_block_t   weight_rep;
  logic                   weight_rep_valid;
  logic                   weight_rep_ready;
  mxint_pkg::mx_block_t   bias_rep;
  logic                   bias_rep_valid;
  logic                   bias_rep_ready;
  mxint_pkg::wide_block_t wide_out;
  logic                   wide_out_valid;
  logic                   wide_out_ready;

  // Parameters are loaded once and replayed for every row
  mxint_circular #(
    .ROW_BLOCKS(ROW_BLOCKS),
    .ROWS      (ROWS)
  ) weight_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  (weight_in),
    .in_valid (weight_in_valid),
    .in_ready (weight_in_ready),
    .out_data (weight_rep),
    .out_valid(weight_rep_valid),
    .out_ready(weight_rep_ready)
  );

  mxint_circular #(
    .ROW_BLOCKS(ROW_BLOCKS),
    .ROWS      (ROWS)
  ) bias_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  (bias_in),
    .in_valid (bias_in_valid),
    .in_ready (bias_in_ready),
    .out_data (bias_rep),
    .out_valid(bias_rep_valid),
    .out_ready(bias_rep_ready)
  );

  mxint_affine u_affine (
    .clk         (clk),
    .rst_n       (rst_n),
    .norm_data   (norm_in),
    .norm_valid  (norm_in_valid),
    .norm_ready  (norm_in_ready),
    .weight_data (weight_rep),
    .weight_valid(weight_rep_valid),
    .weight_ready(weight_rep_ready),
    .bias_data   (bias_rep),
    .bias_valid  (bias_rep_valid),
    .bias_ready  (bias_rep_ready),
    .out_data    (wide_out),
    .out_valid   (wide_out_valid),
    .out_ready   (wide_out_ready)
  );

  mxint_cast u_cast (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  (wide_out),
    .in_valid (wide_out_valid),
    .in_ready (wide_out_ready),
    .out_data (data_out),
    .out_valid(data_out_valid),
    .out_ready(data_out_ready)
  );

endmodule

`default_nettype wire

/* mxint_pkg.sv */
`default_nettype none

package mxint_pkg;

  // Number of mantissas that share one exponent
  localparam int BLOCK_SIZE = 4;

  // Narrow format used for input, weight, bias and output blocks
  localparam int MAN_W = 8;  // Signed, MAN_W-1 fraction bits
  localparam int EXP_W = 4;  // Signed

  // Product plus aligned bias, one guard bit above the full product
  localparam int WIDE_MAN_W = 2 * MAN_W + 1;
  localparam int WIDE_EXP_W = EXP_W + 1;  // Holds the sum of two narrow exponents

  // Element value is man * 2^(exp - (MAN_W-1))
  typedef struct packed {
    logic [BLOCK_SIZE-1:0][MAN_W-1:0] man;
    logic [EXP_W-1:0]                 exp;
  } mx_block_t;

  // Wide block between the affine stage and the cast
  // Mantissas carry 2*(MAN_W-1) fraction bits
  typedef struct packed {
    logic [BLOCK_SIZE-1:0][WIDE_MAN_W-1:0] man;
    logic [WIDE_EXP_W-1:0]                 exp;
  } wide_block_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_mxint_layernorm_affine
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation failed, see $LOG"
exit 1

/* sources.f */
mxint_pkg.sv
mxint_circular.sv
mxint_affine.sv
mxint_cast.sv
mxint_layernorm_affine.sv
tb_mxint_layernorm_affine.sv

/* tb_mxint_layernorm_affine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mxint_layernorm_affine;

  localparam int          ROW_BLOCKS = 2;
  localparam int          ROWS       = 4;
  localparam logic [31:0] SEED       = 32'hf946ee48;

  logic                 clk;
  logic                 rst_n;
  mxint_pkg::mx_block_t norm_in;
  logic                 norm_in_valid;
  logic                 norm_in_ready;
  mxint_pkg::mx_block_t weight_in;
  logic                 weight_in_valid;
  logic                 weight_in_ready;
  mxint_pkg::mx_block_t bias_in;
  logic                 bias_in_valid;
  logic                 bias_in_ready;
  mxint_pkg::mx_block_t data_out;
  logic                 data_out_valid;
  logic                 data_out_ready;

  // Records from the golden file, tensors stored one after the other
  mxint_pkg::mx_block_t w_q [$];
  mxint_pkg::mx_block_t b_q [$];
  mxint_pkg::mx_block_t n_q [$];
  mxint_pkg::mx_block_t o_q [$];

  int error_count   = 0;
  int tests_run     = 0;
  int tests_failed  = 0;
  int cycle_count   = 0;
  int timeout_limit = 0;

  mxint_layernorm_affine #(
    .ROW_BLOCKS(ROW_BLOCKS),
    .ROWS      (ROWS)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .norm_in        (norm_in),
    .norm_in_valid  (norm_in_valid),
    .norm_in_ready  (norm_in_ready),
    .weight_in      (weight_in),
    .weight_in_valid(weight_in_valid),
    .weight_in_ready(weight_in_ready),
    .bias_in        (bias_in),
    .bias_in_valid  (bias_in_valid),
    .bias_in_ready  (bias_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : watchdog
    wait (timeout_limit > 0);
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles before all tests finished", cycle_count);
    $display("Finished with errors");
    $finish;
  end

  // Random gaps only when stalls are enabled
  function automatic bit offer(input bit stalls);
    return !stalls || ($urandom % 3) != 0;
  endfunction

  task automatic read_golden(output bit ok);
    int                   fd;
    int                   f0;
    int                   f1;
    int                   f2;
    int                   f3;
    int                   f4;
    byte                  tag;
    string                line;
    string                rest;
    mxint_pkg::mx_block_t blk;
    ok = 1'b0;
    fd = $fopen("affine_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open affine_golden.txt for reading");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2) continue;
      tag = line.getc(0);
      if (tag == "#") continue;  // Comment line
      rest = line.substr(1, line.len() - 1);
      if ($sscanf(rest, "%h %h %h %h %h", f0, f1, f2, f3, f4) != 5) begin
        $display("Skipped a malformed golden record: %s", line);
        continue;
      end
      blk.man[0] = f0[mxint_pkg::MAN_W-1:0];
      blk.man[1] = f1[mxint_pkg::MAN_W-1:0];
      blk.man[2] = f2[mxint_pkg::MAN_W-1:0];
      blk.man[3] = f3[mxint_pkg::MAN_W-1:0];
      blk.exp    = f4[mxint_pkg::EXP_W-1:0];
      case (tag)
        "W": w_q.push_back(blk);
        "B": b_q.push_back(blk);
        "N": n_q.push_back(blk);
        "O": o_q.push_back(blk);
        default: $display("Unknown record tag in golden file: %s", line);
      endcase
    end
    $fclose(fd);
    timeout_limit = 20 * (w_q.size() + b_q.size() + n_q.size() + o_q.size()) + 200;
    ok = w_q.size() == 2 * ROW_BLOCKS && b_q.size() == 2 * ROW_BLOCKS &&
         n_q.size() == 2 * ROW_BLOCKS * ROWS && o_q.size() == n_q.size();
    if (!ok) $display("Golden file does not hold two complete tensors of records");
  endtask

  task automatic check_reset();
    int errs_before = error_count;
    #1;
    if (data_out_valid !== 1'b0) begin
      $display("CHECK FAILED at %0t: data_out_valid is %b after reset", $time, data_out_valid);
      error_count++;
    end
    if (weight_in_ready !== 1'b1 || bias_in_ready !== 1'b1) begin
      $display("CHECK FAILED at %0t: parameter readies %b %b after reset, expected 1 1",
               $time, weight_in_ready, bias_in_ready);
      error_count++;
    end
    tests_run++;
    if (error_count != errs_before) tests_failed++;
    $display("Test reset state: %0d errors", error_count - errs_before);
  endtask

  task automatic run_tensor(input int tensor, input bit stalls, input string label);
    int base_p      = tensor * ROW_BLOCKS;
    int base_n      = tensor * ROW_BLOCKS * ROWS;
    int total       = ROW_BLOCKS * ROWS;
    int errs_before = error_count;
    int w_idx       = 0;
    int b_idx       = 0;
    int n_idx       = 0;
    int o_idx       = 0;
    bit w_fire      = 1'b0;
    bit b_fire      = 1'b0;
    bit n_fire      = 1'b0;
    while (o_idx < total) begin
      @(negedge clk);
      // Handshakes sampled last cycle completed on the rising edge just passed
      if (w_fire) w_idx++;
      if (b_fire) b_idx++;
      if (n_fire) n_idx++;
      if (!weight_in_valid || w_fire) begin
        weight_in_valid = w_idx < ROW_BLOCKS && offer(stalls);
        if (weight_in_valid) weight_in = w_q[base_p + w_idx];
      end
      if (!bias_in_valid || b_fire) begin
        bias_in_valid = b_idx < ROW_BLOCKS && offer(stalls);
        if (bias_in_valid) bias_in = b_q[base_p + b_idx];
      end
      if (!norm_in_valid || n_fire) begin
        norm_in_valid = n_idx < total && offer(stalls);
        if (norm_in_valid) norm_in = n_q[base_n + n_idx];
      end
      data_out_ready = !stalls || ($urandom % 5) >= 2;
      #1;
      w_fire = weight_in_valid && weight_in_ready;
      b_fire = bias_in_valid && bias_in_ready;
      n_fire = norm_in_valid && norm_in_ready;
      if (data_out_valid && data_out_ready) begin
        if (data_out !== o_q[base_n + o_idx]) begin
          $display("CHECK FAILED at %0t: %s output %0d expected %h got %h",
                   $time, label, o_idx, o_q[base_n + o_idx], data_out);
          error_count++;
        end
        o_idx++;
      end
      // Loaded parameters stay in the buffers until every input block of the tensor is in
      if (w_idx == ROW_BLOCKS && n_idx < total && weight_in_ready) begin
        $display("CHECK FAILED at %0t: %s weight_in_ready high during replay", $time, label);
        error_count++;
      end
      if (b_idx == ROW_BLOCKS && n_idx < total && bias_in_ready) begin
        $display("CHECK FAILED at %0t: %s bias_in_ready high during replay", $time, label);
        error_count++;
      end
    end
    @(negedge clk);
    data_out_ready = 1'b1;
    #1;
    if (data_out_valid) begin
      $display("CHECK FAILED at %0t: %s extra output block %h", $time, label, data_out);
      error_count++;
    end
    if (!weight_in_ready || !bias_in_ready) begin
      $display("CHECK FAILED at %0t: %s buffers not back in load phase", $time, label);
      error_count++;
    end
    tests_run++;
    if (error_count != errs_before) tests_failed++;
    $display("Test %s: %0d blocks, %0d errors", label, total, error_count - errs_before);
  endtask

  initial begin : main
    bit ok;
    rst_n           = 1'b0;
    norm_in         = '0;
    norm_in_valid   = 1'b0;
    weight_in       = '0;
    weight_in_valid = 1'b0;
    bias_in         = '0;
    bias_in_valid   = 1'b0;
    data_out_ready  = 1'b0;
    void'($urandom(SEED));
    read_golden(ok);
    if (!ok) error_count++;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    if (ok) begin
      check_reset();
      run_tensor(0, 1'b0, "tensor 0 without stalls");
      run_tensor(0, 1'b1, "tensor 0 with random stalls");
      run_tensor(1, 1'b1, "tensor 1 reloaded with random stalls");
    end
    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
